//--- bench/rv_core_assertions.sv
module rv_core_assertions (
    input logic clk,
    input logic rst_n,
    input logic id_valid,
    input logic stall,
    input logic redirect
);

    timeunit 1ns;
    timeprecision 1ps;

    int fail_count = 0;

    ////////////////////
    // redirect rules.
    property redirect_single;
        @(posedge clk) disable iff (!rst_n) redirect |=> !redirect;
    endproperty

    // the redirecting entry left decode as a live instruction.
    property redirect_from_valid;
        @(posedge clk) disable iff (!rst_n)
            redirect |-> $past(id_valid && !stall && !redirect);
    endproperty

    // first cycle out of reset.
    property quiet_after_reset;
        @(posedge clk) $rose(rst_n) |-> (!stall && !redirect);
    endproperty

    assert property (redirect_single) else begin
        fail_count++;
        $error("redirect high for two cycles");
    end
    assert property (redirect_from_valid) else begin
        fail_count++;
        $error("redirect from an invalid entry");
    end
    assert property (quiet_after_reset) else begin
        fail_count++;
        $error("stall or redirect right after reset");
    end

endmodule

bind decode_stage rv_core_assertions dec_checks (
    .clk(clk), .rst_n(rst_n), .id_valid(id_valid), .stall(stall), .redirect(redirect));

//--- bench/rv_core_tb.sv
module rv_core_tb;

    timeunit 1ns;
    timeprecision 1ps;

    logic                       clk;
    logic                       rst_n;
    logic                       imem_we;
    logic [rv_pkg::IMEM_AW-1:0] imem_addr;
    logic [rv_pkg::XLEN-1:0]    imem_data;
    logic                       io_valid;
    logic [rv_pkg::XLEN-1:0]    io_data;

    logic [31:0] prog [$];
    logic [31:0] expected [$];
    int seed = 32'h68c7_8128;
    int errors = 0;
    int received = 0;
    int limit_cycles = 0;
    bit ready = 0;

    rv_core rv_core_inst (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    ////////////////////
    // encoders.
    function automatic logic [31:0] r_type(logic [6:0] f7, logic [4:0] rs2, logic [4:0] rs1,
                                           logic [2:0] f3, logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, rv_pkg::OP_REG};
    endfunction

    function automatic logic [31:0] i_type(logic [11:0] imm, logic [4:0] rs1, logic [2:0] f3,
                                           logic [4:0] rd, logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] s_type(logic [11:0] imm, logic [4:0] rs2, logic [4:0] rs1);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], rv_pkg::OP_STORE};
    endfunction

    function automatic logic [31:0] b_type(logic [12:0] imm, logic [4:0] rs2, logic [4:0] rs1,
                                           logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], rv_pkg::OP_BRANCH};
    endfunction

    function automatic logic [31:0] u_type(logic [19:0] imm, logic [4:0] rd, logic [6:0] op);
        return {imm, rd, op};
    endfunction

    function automatic logic [31:0] j_type(logic [20:0] imm, logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, rv_pkg::OP_JAL};
    endfunction

    function int pick(int lo, int hi);
        return lo + int'($unsigned($random(seed)) % (hi - lo + 1));
    endfunction

    task automatic build_program();
        logic [2:0]  f3;
        logic [11:0] imm;
        logic [2:0]  kinds [6] = '{3'b000, 3'b001, 3'b100, 3'b101, 3'b110, 3'b111};
        int          rd;
        int          prev;
        int          base;
        prog.push_back(u_type(20'h1, 5'd31, rv_pkg::OP_LUI)); // x31 = io address.
        for (int k = 1; k <= 6; k++) begin
            prog.push_back(i_type(12'($random(seed)), 5'd0, 3'b000, 5'(k), rv_pkg::OP_IMM));
        end
        prev = 1;
        // dependent alu chain, each result to io.
        for (int k = 0; k < 14; k++) begin
            f3 = 3'(pick(0, 7));
            rd = (k == 7) ? 0 : pick(0, 6); // one result aimed at x0.
            if (pick(0, 1) == 1) begin
                prog.push_back(r_type(((f3 == 3'b000 || f3 == 3'b101) && pick(0, 1) == 1)
                                      ? 7'h20 : 7'h00, 5'(pick(0, 6)), 5'(prev), f3, 5'(rd)));
            end else begin
                imm = 12'($random(seed));
                if (f3 == 3'b001 || f3 == 3'b101) begin
                    imm = {1'b0, (f3 == 3'b101) ? 1'(pick(0, 1)) : 1'b0, 5'b0, imm[4:0]};
                end
                prog.push_back(i_type(imm, 5'(prev), f3, 5'(rd), rv_pkg::OP_IMM));
            end
            prog.push_back(s_type(12'd0, 5'(rd), 5'd31));
            prev = rd;
        end
        // store, load, use.
        for (int k = 0; k < 3; k++) begin
            base = pick(0, 200) * 4;
            prog.push_back(i_type(12'(base), 5'd0, 3'b000, 5'd7, rv_pkg::OP_IMM));
            prog.push_back(s_type(12'd0, 5'd1, 5'd7));
            prog.push_back(s_type(12'd4, 5'd2, 5'd7));
            prog.push_back(i_type(12'd0, 5'd7, 3'b010, 5'd3, rv_pkg::OP_LOAD));
            prog.push_back(r_type(7'h00, 5'd2, 5'd3, 3'b000, 5'd4));
            prog.push_back(s_type(12'd0, 5'd4, 5'd31));
            prog.push_back(i_type(12'd4, 5'd7, 3'b010, 5'd5, rv_pkg::OP_LOAD));
            prog.push_back(s_type(12'd0, 5'd5, 5'd31));
        end
        prog.push_back(u_type(20'($random(seed)), 5'd8, rv_pkg::OP_LUI));
        prog.push_back(i_type(12'($random(seed)), 5'd8, 3'b000, 5'd8, rv_pkg::OP_IMM));
        prog.push_back(u_type(20'($random(seed)), 5'd9, rv_pkg::OP_LUI));
        // each kind with (a,b), (b,a) and (a,a); stores in killed slots.
        for (int k = 0; k < 18; k++) begin
            prog.push_back(i_type(12'(k + 1), 5'd0, 3'b000, 5'd6, rv_pkg::OP_IMM));
            prog.push_back(b_type(13'd12, (k % 3 == 0) ? 5'd9 : 5'd8,
                                  (k % 3 == 1) ? 5'd9 : 5'd8, kinds[k / 3]));
            prog.push_back(s_type(12'd0, 5'd6, 5'd31));
            prog.push_back(s_type(12'd0, 5'd6, 5'd31));
            prog.push_back(s_type(12'd0, 5'd8, 5'd31));
        end
        // jumps and links.
        prog.push_back(j_type(21'd12, 5'd10));
        prog.push_back(s_type(12'd0, 5'd6, 5'd31));
        prog.push_back(s_type(12'd0, 5'd6, 5'd31));
        prog.push_back(s_type(12'd0, 5'd10, 5'd31));
        prog.push_back(j_type(21'd12, 5'd11));
        prog.push_back(s_type(12'd0, 5'd11, 5'd31)); // return lands here.
        prog.push_back(j_type(21'd12, 5'd0));
        prog.push_back(i_type(12'd77, 5'd0, 3'b000, 5'd12, rv_pkg::OP_IMM));
        prog.push_back(i_type(12'd1, 5'd11, 3'b000, 5'd13, rv_pkg::OP_JALR)); // bit 0 dropped.
        prog.push_back(s_type(12'd0, 5'd13, 5'd31));
        prog.push_back(s_type(12'd0, 5'd12, 5'd31));
        prog.push_back(u_type(20'($random(seed)), 5'd14, rv_pkg::OP_LUI));
        prog.push_back(s_type(12'd0, 5'd14, 5'd31));
        prog.push_back(u_type(20'($random(seed)), 5'd15, rv_pkg::OP_AUIPC));
        prog.push_back(s_type(12'd0, 5'd15, 5'd31));
        prog.push_back(j_type(21'd0, 5'd0)); // self-loop.
        for (int k = 0; k < 4; k++) begin
            prog.push_back(i_type(12'd0, 5'd0, 3'b000, 5'd0, rv_pkg::OP_IMM));
        end
    endtask

    function automatic logic [31:0] compute_alu(logic [2:0] f3, logic alt, logic [31:0] a,
                                                logic [31:0] b);
        case (f3)
            3'b000:  return alt ? a - b : a + b;
            3'b001:  return a << b[4:0];
            3'b010:  return {31'b0, $signed(a) < $signed(b)};
            3'b011:  return {31'b0, a < b};
            3'b100:  return a ^ b;
            3'b101:  return alt ? 32'($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'b110:  return a | b;
            default: return a & b;
        endcase
    endfunction

    ////////////////////
    // isa reference model.
    function automatic int run_reference();
        logic [31:0] regs [32];
        logic [31:0] dmem [int];
        logic [31:0] pc, inst, a, b, immi, imms, immb, immj, nxt;
        logic [4:0]  rd;
        logic [2:0]  f3;
        logic        take;
        int          steps;
        for (int i = 0; i < 32; i++) regs[i] = '0;
        expected.delete();
        pc = 0;
        steps = 0;
        while (steps < 4000 && (pc >> 2) < prog.size()) begin
            inst = prog[pc >> 2];
            if (inst == j_type(21'd0, 5'd0)) break;
            rd   = inst[11:7];
            f3   = inst[14:12];
            a    = regs[inst[19:15]];
            b    = regs[inst[24:20]];
            immi = {{20{inst[31]}}, inst[31:20]};
            imms = {{20{inst[31]}}, inst[31:25], inst[11:7]};
            immb = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
            immj = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
            nxt  = pc + 4;
            case (inst[6:0])
                rv_pkg::OP_LUI:   regs[rd] = {inst[31:12], 12'b0};
                rv_pkg::OP_AUIPC: regs[rd] = pc + {inst[31:12], 12'b0};
                rv_pkg::OP_JAL: begin
                    regs[rd] = pc + 4;
                    nxt = pc + immj;
                end
                rv_pkg::OP_JALR: begin
                    nxt = (a + immi) & ~32'd1;
                    regs[rd] = pc + 4;
                end
                rv_pkg::OP_BRANCH: begin
                    case (f3)
                        3'b000:  take = a == b;
                        3'b001:  take = a != b;
                        3'b100:  take = $signed(a) < $signed(b);
                        3'b101:  take = $signed(a) >= $signed(b);
                        3'b110:  take = a < b;
                        default: take = a >= b;
                    endcase
                    if (take) nxt = pc + immb;
                end
                rv_pkg::OP_LOAD:  regs[rd] = dmem[int'((a + immi) >> 2)];
                rv_pkg::OP_STORE: begin
                    if (a + imms == rv_pkg::IO_ADDR) expected.push_back(b);
                    else dmem[int'((a + imms) >> 2)] = b;
                end
                rv_pkg::OP_IMM: regs[rd] = compute_alu(f3, f3 == 3'b101 && inst[30], a, immi);
                default:        regs[rd] = compute_alu(f3, inst[30], a, b);
            endcase
            regs[0] = '0;
            pc = nxt;
            steps++;
        end
        return expected.size();
    endfunction

    // compares each io pulse against the model.
    always @(negedge clk) begin
        if (io_valid) begin
            assert (rst_n) else begin
                errors++;
                $display("io_valid went high while the core was in reset at %0t", $time);
            end
            assert (received < expected.size()) else begin
                errors++;
                $display("extra io store at %0t with io_data %h", $time, io_data);
            end
            if (rst_n && received < expected.size()) begin
                assert (io_data == expected[received]) else begin
                    errors++;
                    $display("Mismatch at %0t: io_data expected %h actual %h",
                             $time, expected[received], io_data);
                end
                received++;
            end
        end
    end

    initial begin
        wait (ready);
        repeat (limit_cycles) @(posedge clk);
        $display("timeout: core stopped producing output, %0d of %0d stores seen, errors %0d",
                 received, expected.size(),
                 errors + rv_core_inst.decode_stage_inst.dec_checks.fail_count);
        $display("TEST FAIL");
        $finish;
    end

    initial begin
        rst_n     = 1'b0;
        imem_we   = 1'b0;
        imem_addr = '0;
        imem_data = '0;
        build_program();
        void'(run_reference());
        limit_cycles = prog.size() * 20 + 200;
        ready = 1;
        @(posedge clk);
        foreach (prog[i]) begin
            #1;
            imem_we   = 1'b1;
            imem_addr = rv_pkg::IMEM_AW'(i);
            imem_data = prog[i];
            @(posedge clk);
        end
        #1 imem_we = 1'b0;
        repeat (3) @(posedge clk);
        #1 rst_n = 1'b1;
        wait (received == expected.size());
        repeat (2) @(posedge clk);
        @(negedge clk);
        #1;
        errors += rv_core_inst.decode_stage_inst.dec_checks.fail_count;
        $display("errors %0d, io stores %0d of %0d", errors, received, expected.size());
        if (errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

//--- project.f
src/rv_pkg.sv
src/fetch_stage.sv
src/decode_stage.sv
src/execute_stage.sv
src/memory_stage.sv
src/rv_core.sv
bench/rv_core_assertions.sv
bench/rv_core_tb.sv

//--- run.sh
#!/usr/bin/env bash
# Build and run the rv_core testbench with Verilator.

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    -f project.f --top-module rv_core_tb -o rv_core_sim
if [ $? -ne 0 ]; then
    echo "compile failed"
    exit 1
fi

./obj_dir/rv_core_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "TEST FAIL" "$LOG"; then
    exit 1
fi
if ! grep -q "TEST PASS" "$LOG"; then
    echo "no result line in $LOG"
    exit 1
fi
exit 0

//--- src/decode_stage.sv
module decode_stage (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      id_valid,
    input  logic [rv_pkg::XLEN-1:0]   id_inst,
    input  logic [rv_pkg::XLEN-1:0]   id_pc,
    input  logic [rv_pkg::XLEN-1:0]   id_pc_plus4,
    input  logic                      redirect,
    input  logic                      wb_we,
    input  logic [rv_pkg::REG_AW-1:0] wb_rd,
    input  logic [rv_pkg::XLEN-1:0]   wb_data,
    output logic                      stall,
    output logic                      ex_valid,
    output logic [rv_pkg::XLEN-1:0]   ex_pc,
    output logic [rv_pkg::XLEN-1:0]   ex_pc_plus4,
    output logic [rv_pkg::REG_AW-1:0] ex_rs1,
    output logic [rv_pkg::REG_AW-1:0] ex_rs2,
    output logic [rv_pkg::XLEN-1:0]   ex_rs1_val,
    output logic [rv_pkg::XLEN-1:0]   ex_rs2_val,
    output logic [rv_pkg::XLEN-1:0]   ex_imm,
    output logic [rv_pkg::REG_AW-1:0] ex_rd,
    output rv_pkg::alu_op_t           ex_alu_op,
    output logic                      ex_use_imm,
    output logic                      ex_reg_write,
    output logic                      ex_mem_read,
    output logic                      ex_mem_write,
    output logic                      ex_is_branch,
    output logic [2:0]                ex_branch_f3,
    output logic                      ex_is_jal,
    output logic                      ex_is_jalr,
    output logic                      ex_pc_to_reg,
    output logic                      ex_use_pc
);

    logic [rv_pkg::XLEN-1:0]   rf [32];
    rv_pkg::opcode_t           op;
    rv_pkg::alu_op_t           alu_sel;
    rv_pkg::alu_op_t           alu_op;
    logic [rv_pkg::REG_AW-1:0] rs1;
    logic [rv_pkg::REG_AW-1:0] rs2;
    logic [2:0]                f3;
    logic [rv_pkg::XLEN-1:0]   imm_i, imm_s, imm_b, imm_u, imm_j, imm;
    logic use_imm, reg_write, mem_read, mem_write, is_branch;
    logic is_jal, is_jalr, pc_to_reg, use_pc, uses_rs1, uses_rs2;

    assign op  = rv_pkg::opcode_t'(id_inst[6:0]);
    assign rs1 = id_inst[rv_pkg::RS1_LSB +: rv_pkg::REG_AW];
    assign rs2 = id_inst[rv_pkg::RS2_LSB +: rv_pkg::REG_AW];
    assign f3  = id_inst[rv_pkg::F3_LSB +: 3];

    assign imm_i = {{20{id_inst[31]}}, id_inst[31:20]};
    assign imm_s = {{20{id_inst[31]}}, id_inst[31:25], id_inst[11:7]};
    assign imm_b = {{19{id_inst[31]}}, id_inst[31], id_inst[7], id_inst[30:25],
                    id_inst[11:8], 1'b0};
    assign imm_u = {id_inst[31:12], 12'b0};
    assign imm_j = {{11{id_inst[31]}}, id_inst[31], id_inst[19:12], id_inst[20],
                    id_inst[30:21], 1'b0};

    function automatic logic [rv_pkg::XLEN-1:0] rf_read(input logic [rv_pkg::REG_AW-1:0] idx);
        if (idx == '0) begin
            return '0; // x0.
        end else if (wb_we && wb_rd == idx) begin
            return wb_data; // write-through.
        end
        return rf[idx];
    endfunction

    always_comb begin
        case (f3)
            rv_pkg::F3_ADD:  alu_sel = (op == rv_pkg::OP_REG && id_inst[rv_pkg::ALT_BIT])
                                       ? rv_pkg::SUB : rv_pkg::ADD;
            rv_pkg::F3_SLL:  alu_sel = rv_pkg::SLL;
            rv_pkg::F3_SLT:  alu_sel = rv_pkg::SLT;
            rv_pkg::F3_SLTU: alu_sel = rv_pkg::SLTU;
            rv_pkg::F3_XOR:  alu_sel = rv_pkg::XOR;
            rv_pkg::F3_SR:   alu_sel = id_inst[rv_pkg::ALT_BIT] ? rv_pkg::SRA : rv_pkg::SRL;
            rv_pkg::F3_OR:   alu_sel = rv_pkg::OR;
            default:         alu_sel = rv_pkg::AND;
        endcase
    end

    always_comb begin
        {use_imm, reg_write, mem_read, mem_write, is_branch} = '0;
        {is_jal, is_jalr, pc_to_reg, use_pc, uses_rs1, uses_rs2} = '0;
        alu_op = rv_pkg::ADD;
        imm    = imm_i;
        case (op)
            rv_pkg::OP_LUI: begin
                {reg_write, use_imm} = 2'b11;
                alu_op = rv_pkg::PASS_B;
                imm    = imm_u;
            end
            rv_pkg::OP_AUIPC: begin
                {reg_write, use_imm, use_pc} = 3'b111;
                imm = imm_u;
            end
            rv_pkg::OP_JAL: begin
                {reg_write, is_jal, pc_to_reg} = 3'b111;
                imm = imm_j;
            end
            rv_pkg::OP_JALR:   {reg_write, is_jalr, pc_to_reg, uses_rs1} = 4'b1111;
            rv_pkg::OP_BRANCH: begin
                {is_branch, uses_rs1, uses_rs2} = 3'b111;
                imm = imm_b;
            end
            rv_pkg::OP_LOAD:   {reg_write, mem_read, use_imm, uses_rs1} = 4'b1111;
            rv_pkg::OP_STORE: begin
                {mem_write, use_imm, uses_rs1, uses_rs2} = 4'b1111;
                imm = imm_s;
            end
            rv_pkg::OP_IMM: begin
                {reg_write, use_imm, uses_rs1} = 3'b111;
                alu_op = alu_sel;
            end
            rv_pkg::OP_REG: begin
                {reg_write, uses_rs1, uses_rs2} = 3'b111;
                alu_op = alu_sel;
            end
            default: ; // unknown opcode acts as a nop.
        endcase
    end

    // load in execute feeding this instruction.
    assign stall = id_valid && ex_valid && ex_mem_read && ex_rd != '0 &&
                   ((uses_rs1 && rs1 == ex_rd) || (uses_rs2 && rs2 == ex_rd));

    always_ff @(posedge clk) begin
        if (wb_we && wb_rd != '0) begin
            rf[wb_rd] <= wb_data;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n || !id_valid || stall || redirect) begin
            ex_valid <= 1'b0; // bubble.
            {ex_use_imm, ex_reg_write, ex_mem_read, ex_mem_write, ex_is_branch} <= '0;
            {ex_is_jal, ex_is_jalr, ex_pc_to_reg, ex_use_pc} <= '0;
        end else begin
            ex_valid <= 1'b1;
            {ex_use_imm, ex_reg_write, ex_mem_read, ex_mem_write, ex_is_branch} <=
                {use_imm, reg_write, mem_read, mem_write, is_branch};
            {ex_is_jal, ex_is_jalr, ex_pc_to_reg, ex_use_pc} <=
                {is_jal, is_jalr, pc_to_reg, use_pc};
        end
    end

    always_ff @(posedge clk) begin
        ex_pc        <= id_pc;
        ex_pc_plus4  <= id_pc_plus4;
        ex_rs1       <= rs1;
        ex_rs2       <= rs2;
        ex_rs1_val   <= rf_read(rs1);
        ex_rs2_val   <= rf_read(rs2);
        ex_imm       <= imm;
        ex_rd        <= id_inst[rv_pkg::RD_LSB +: rv_pkg::REG_AW];
        ex_alu_op    <= alu_op;
        ex_branch_f3 <= f3;
    end

endmodule

//--- src/execute_stage.sv
module execute_stage (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      ex_valid,
    input  logic [rv_pkg::XLEN-1:0]   ex_pc,
    input  logic [rv_pkg::XLEN-1:0]   ex_pc_plus4,
    input  logic [rv_pkg::REG_AW-1:0] ex_rs1,
    input  logic [rv_pkg::REG_AW-1:0] ex_rs2,
    input  logic [rv_pkg::XLEN-1:0]   ex_rs1_val,
    input  logic [rv_pkg::XLEN-1:0]   ex_rs2_val,
    input  logic [rv_pkg::XLEN-1:0]   ex_imm,
    input  logic [rv_pkg::REG_AW-1:0] ex_rd,
    input  rv_pkg::alu_op_t           ex_alu_op,
    input  logic                      ex_use_imm,
    input  logic                      ex_reg_write,
    input  logic                      ex_mem_read,
    input  logic                      ex_mem_write,
    input  logic                      ex_is_branch,
    input  logic [2:0]                ex_branch_f3,
    input  logic                      ex_is_jal,
    input  logic                      ex_is_jalr,
    input  logic                      ex_pc_to_reg,
    input  logic                      ex_use_pc,
    input  logic [rv_pkg::REG_AW-1:0] mem_rd,
    input  logic                      mem_reg_write,
    input  logic [rv_pkg::XLEN-1:0]   mem_result,
    input  logic                      wb_we,
    input  logic [rv_pkg::REG_AW-1:0] wb_rd,
    input  logic [rv_pkg::XLEN-1:0]   wb_data,
    output logic                      redirect,
    output logic [rv_pkg::XLEN-1:0]   redirect_pc,
    output logic                      ma_valid,
    output logic [rv_pkg::XLEN-1:0]   ma_result,
    output logic [rv_pkg::XLEN-1:0]   ma_store_data,
    output logic [rv_pkg::REG_AW-1:0] ma_rd,
    output logic                      ma_reg_write,
    output logic                      ma_mem_read,
    output logic                      ma_mem_write
);

    logic [rv_pkg::XLEN-1:0] rs1_val, rs2_val, op_a, op_b, alu_y, jalr_target;
    logic                    cond;

    // memory stage is younger than write-back, so it wins.
    function automatic logic [rv_pkg::XLEN-1:0] fwd(input logic [rv_pkg::REG_AW-1:0] idx,
                                                    input logic [rv_pkg::XLEN-1:0] reg_val);
        if (idx != '0 && mem_reg_write && mem_rd == idx) begin
            return mem_result;
        end else if (idx != '0 && wb_we && wb_rd == idx) begin
            return wb_data;
        end
        return reg_val;
    endfunction

    assign rs1_val = fwd(ex_rs1, ex_rs1_val);
    assign rs2_val = fwd(ex_rs2, ex_rs2_val);
    assign op_a    = ex_use_pc ? ex_pc : rs1_val;
    assign op_b    = ex_use_imm ? ex_imm : rs2_val;

    always_comb begin
        case (ex_alu_op)
            rv_pkg::ADD:  alu_y = op_a + op_b;
            rv_pkg::SUB:  alu_y = op_a - op_b;
            rv_pkg::SLL:  alu_y = op_a << op_b[4:0];
            rv_pkg::SLT:  alu_y = {31'b0, $signed(op_a) < $signed(op_b)};
            rv_pkg::SLTU: alu_y = {31'b0, op_a < op_b};
            rv_pkg::XOR:  alu_y = op_a ^ op_b;
            rv_pkg::SRL:  alu_y = op_a >> op_b[4:0];
            rv_pkg::SRA:  alu_y = $signed(op_a) >>> op_b[4:0];
            rv_pkg::OR:   alu_y = op_a | op_b;
            rv_pkg::AND:  alu_y = op_a & op_b;
            default:      alu_y = op_b; // pass_b for lui.
        endcase
    end

    ////////////////////
    // branch resolution.
    always_comb begin
        case (ex_branch_f3)
            rv_pkg::F3_BEQ:  cond = rs1_val == rs2_val;
            rv_pkg::F3_BNE:  cond = rs1_val != rs2_val;
            rv_pkg::F3_BLT:  cond = $signed(rs1_val) < $signed(rs2_val);
            rv_pkg::F3_BGE:  cond = $signed(rs1_val) >= $signed(rs2_val);
            rv_pkg::F3_BLTU: cond = rs1_val < rs2_val;
            rv_pkg::F3_BGEU: cond = rs1_val >= rs2_val;
            default:         cond = 1'b0;
        endcase
    end

    assign jalr_target = rs1_val + ex_imm;
    assign redirect    = ex_valid && (ex_is_jal || ex_is_jalr || (ex_is_branch && cond));
    assign redirect_pc = ex_is_jalr ? {jalr_target[31:1], 1'b0} : ex_pc + ex_imm;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ma_valid <= 1'b0;
            {ma_reg_write, ma_mem_read, ma_mem_write} <= '0;
        end else begin
            ma_valid <= ex_valid;
            {ma_reg_write, ma_mem_read, ma_mem_write} <= {ex_reg_write, ex_mem_read, ex_mem_write};
        end
    end

    always_ff @(posedge clk) begin
        ma_result     <= ex_pc_to_reg ? ex_pc_plus4 : alu_y; // link value.
        ma_store_data <= rs2_val;
        ma_rd         <= ex_rd;
    end

endmodule

//--- src/fetch_stage.sv
module fetch_stage (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       imem_we,
    input  logic [rv_pkg::IMEM_AW-1:0] imem_addr,
    input  logic [rv_pkg::XLEN-1:0]    imem_data,
    input  logic                       stall,
    input  logic                       redirect,
    input  logic [rv_pkg::XLEN-1:0]    redirect_pc,
    output logic                       id_valid,
    output logic [rv_pkg::XLEN-1:0]    id_inst,
    output logic [rv_pkg::XLEN-1:0]    id_pc,
    output logic [rv_pkg::XLEN-1:0]    id_pc_plus4
);

    logic [rv_pkg::XLEN-1:0] imem [rv_pkg::IMEM_WORDS];
    logic [rv_pkg::XLEN-1:0] pc;
    logic [rv_pkg::XLEN-1:0] pc_plus4;
    logic [rv_pkg::XLEN-1:0] next_pc;

    assign pc_plus4 = pc + 32'd4;

    // redirect beats stall.
    always_comb begin
        if (redirect) begin
            next_pc = redirect_pc;
        end else if (stall) begin
            next_pc = pc;
        end else begin
            next_pc = pc_plus4;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n && imem_we) begin
            imem[imem_addr] <= imem_data; // preload port.
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc       <= '0;
            id_valid <= 1'b0;
        end else begin
            pc <= next_pc;
            if (redirect) begin
                id_valid <= 1'b0; // killed slot.
            end else if (!stall) begin
                id_valid <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            id_inst     <= imem[pc[rv_pkg::IMEM_AW+1:2]];
            id_pc       <= pc;
            id_pc_plus4 <= pc_plus4;
        end
    end

endmodule

//--- src/memory_stage.sv
module memory_stage (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      ma_valid,
    input  logic [rv_pkg::XLEN-1:0]   ma_result,
    input  logic [rv_pkg::XLEN-1:0]   ma_store_data,
    input  logic [rv_pkg::REG_AW-1:0] ma_rd,
    input  logic                      ma_reg_write,
    input  logic                      ma_mem_read,
    input  logic                      ma_mem_write,
    output logic [rv_pkg::REG_AW-1:0] mem_rd,
    output logic                      mem_reg_write,
    output logic [rv_pkg::XLEN-1:0]   mem_result,
    output logic                      wb_we,
    output logic [rv_pkg::REG_AW-1:0] wb_rd,
    output logic [rv_pkg::XLEN-1:0]   wb_data,
    output logic                      io_valid,
    output logic [rv_pkg::XLEN-1:0]   io_data
);

    logic [rv_pkg::XLEN-1:0]    dmem [rv_pkg::DMEM_WORDS];
    logic [rv_pkg::DMEM_AW-1:0] word;
    logic                       is_io;

    assign word  = ma_result[rv_pkg::DMEM_AW+1:2];
    assign is_io = ma_result == rv_pkg::IO_ADDR;

    // load data is not ready yet, so loads never forward from here.
    assign mem_rd        = ma_rd;
    assign mem_reg_write = ma_valid && ma_reg_write && !ma_mem_read;
    assign mem_result    = ma_result;

    always_ff @(posedge clk) begin
        if (ma_valid && ma_mem_write && !is_io) begin
            dmem[word] <= ma_store_data;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wb_we    <= 1'b0;
            io_valid <= 1'b0;
        end else begin
            wb_we    <= ma_valid && ma_reg_write;
            io_valid <= ma_valid && ma_mem_write && is_io;
        end
    end

    always_ff @(posedge clk) begin
        wb_rd   <= ma_rd;
        wb_data <= ma_mem_read ? dmem[word] : ma_result;
        io_data <= ma_store_data;
    end

endmodule

//--- src/rv_core.sv
module rv_core (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       imem_we,
    input  logic [rv_pkg::IMEM_AW-1:0] imem_addr,
    input  logic [rv_pkg::XLEN-1:0]    imem_data,
    output logic                       io_valid,
    output logic [rv_pkg::XLEN-1:0]    io_data
);

    ////////////////////
    // fetch to decode.
    logic                      id_valid;
    logic [rv_pkg::XLEN-1:0]   id_inst, id_pc, id_pc_plus4;
    logic                      stall;
    logic                      redirect;
    logic [rv_pkg::XLEN-1:0]   redirect_pc;

    ////////////////////
    // decode to execute.
    logic                      ex_valid;
    logic [rv_pkg::XLEN-1:0]   ex_pc, ex_pc_plus4, ex_rs1_val, ex_rs2_val, ex_imm;
    logic [rv_pkg::REG_AW-1:0] ex_rs1, ex_rs2, ex_rd;
    rv_pkg::alu_op_t           ex_alu_op;
    logic                      ex_use_imm, ex_reg_write, ex_mem_read, ex_mem_write;
    logic                      ex_is_branch, ex_is_jal, ex_is_jalr, ex_pc_to_reg, ex_use_pc;
    logic [2:0]                ex_branch_f3;

    ////////////////////
    // execute to memory.
    logic                      ma_valid, ma_reg_write, ma_mem_read, ma_mem_write;
    logic [rv_pkg::XLEN-1:0]   ma_result, ma_store_data;
    logic [rv_pkg::REG_AW-1:0] ma_rd;

    // forwarding and write-back.
    logic [rv_pkg::REG_AW-1:0] mem_rd, wb_rd;
    logic                      mem_reg_write, wb_we;
    logic [rv_pkg::XLEN-1:0]   mem_result, wb_data;

    fetch_stage fetch_stage_inst (.*);

    decode_stage decode_stage_inst (.*);

    execute_stage execute_stage_inst (.*);

    memory_stage memory_stage_inst (.*);

endmodule

//--- src/rv_pkg.sv
package rv_pkg;

    localparam int XLEN = 32;
    localparam int REG_AW = 5;

    ////////////////////
    // memories and io.
    localparam int IMEM_WORDS = 256;
    localparam int DMEM_WORDS = 256;
    localparam int IMEM_AW = $clog2(IMEM_WORDS);
    localparam int DMEM_AW = $clog2(DMEM_WORDS);
    localparam logic [XLEN-1:0] IO_ADDR = 32'h0000_1000;

    ////////////////////
    // instruction fields.
    localparam int RD_LSB = 7;
    localparam int F3_LSB = 12;
    localparam int RS1_LSB = 15;
    localparam int RS2_LSB = 20;
    localparam int ALT_BIT = 30; // selects sub and sra.

    typedef enum logic [6:0] {
        OP_LUI    = 7'b0110111,
        OP_AUIPC  = 7'b0010111,
        OP_JAL    = 7'b1101111,
        OP_JALR   = 7'b1100111,
        OP_BRANCH = 7'b1100011,
        OP_LOAD   = 7'b0000011,
        OP_STORE  = 7'b0100011,
        OP_IMM    = 7'b0010011,
        OP_REG    = 7'b0110011
    } opcode_t;

    // alu funct3.
    localparam logic [2:0] F3_ADD  = 3'b000;
    localparam logic [2:0] F3_SLL  = 3'b001;
    localparam logic [2:0] F3_SLT  = 3'b010;
    localparam logic [2:0] F3_SLTU = 3'b011;
    localparam logic [2:0] F3_XOR  = 3'b100;
    localparam logic [2:0] F3_SR   = 3'b101;
    localparam logic [2:0] F3_OR   = 3'b110;
    localparam logic [2:0] F3_AND  = 3'b111;

    // branch funct3.
    localparam logic [2:0] F3_BEQ  = 3'b000;
    localparam logic [2:0] F3_BNE  = 3'b001;
    localparam logic [2:0] F3_BLT  = 3'b100;
    localparam logic [2:0] F3_BGE  = 3'b101;
    localparam logic [2:0] F3_BLTU = 3'b110;
    localparam logic [2:0] F3_BGEU = 3'b111;

    typedef enum logic [3:0] {
        ADD,
        SUB,
        SLL,
        SLT,
        SLTU,
        XOR,
        SRL,
        SRA,
        OR,
        AND,
        PASS_B
    } alu_op_t;

endpackage
